/* hw/sat_pkg.sv */
`default_nettype none

package sat_pkg;

    // variable index width, 64 variables
    // var 0 is reserved as no literal
    localparam int VAR_W = 6;

    // literal positions per clause
    localparam int CLA_LITS = 3;

    // engine tag width, up to 4 engines
    localparam int ENG_W = 2;

    // literal, sign set means negated
    typedef struct packed {
        logic             sign;
        logic [VAR_W-1:0] var_idx;
    } lit_t;

    // clause node as loaded from outside
    // unused positions have their mask bit clear
    typedef struct packed {
        logic [ENG_W-1:0]    eng;
        lit_t [CLA_LITS-1:0] lits;
        logic [CLA_LITS-1:0] mask;
    } node_t;

endpackage

`default_nettype wire

/* hw/lit_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module lit_fifo #(
    parameter int  DEPTH  = 4,
    parameter type item_t = sat_pkg::lit_t
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  push,
    input  item_t din,
    input  logic  pop,
    output item_t dout,
    output logic  full,
    output logic  empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    item_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;

    // pointer step with wrap, depth need not be a power of two
    function automatic logic [PTR_W-1:0] bump(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full  = (count == (PTR_W + 1)'(DEPTH));
    assign empty = (count == '0);
    // head is visible without a pop
    assign dout  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= bump(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= bump(rd_ptr);
            end
            // simultaneous push and pop keeps the count
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // producer must watch full, consumer must watch empty
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full);
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty);

endmodule

`default_nettype wire

/* hw/scan_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module scan_counter #(
    parameter int CLQ_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start,
    input  logic                         enable,
    output logic [$clog2(CLQ_DEPTH)-1:0] slot,
    output logic                         running,
    output logic                         done
);

    localparam int SLOT_W = $clog2(CLQ_DEPTH);
    localparam logic [SLOT_W-1:0] LAST = SLOT_W'(CLQ_DEPTH - 1);

    // last slot handled this cycle
    assign done = running && enable && (slot == LAST);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot    <= '0;
            running <= 1'b0;
        end else if (start) begin
            slot    <= '0;
            running <= 1'b1;
        end else if (running && enable) begin
            // stalled cycles hold the slot
            if (slot == LAST) begin
                running <= 1'b0;
            end else begin
                slot <= slot + 1'b1;
            end
        end
    end

    a_slot_range: assert property (@(posedge clk) disable iff (!rst_n)
        running |-> (slot < CLQ_DEPTH));

endmodule

`default_nettype wire

/* hw/bcp_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module bcp_engine #(
    parameter int ENG_ID    = 0,
    parameter int CLQ_DEPTH = 8,
    parameter int UCQ_DEPTH = 4
) (
    input  logic           clk,
    input  logic           rst_n,
    input  sat_pkg::node_t clause_node,
    input  logic           clause_push,
    input  sat_pkg::lit_t  bcast_lit,
    input  logic           bcast_push,
    input  logic           ucq_in_pop,
    output logic           clause_full,
    output logic           ucq_out_full,
    output sat_pkg::lit_t  ucq_in_lit,
    output logic           ucq_in_empty,
    output logic           conflict,
    output logic           busy
);

    localparam int SLOT_W = $clog2(CLQ_DEPTH);
    localparam int NL     = sat_pkg::CLA_LITS;

    // clause load path
    logic           clq_push;
    logic           clq_pop;
    logic           clq_empty;
    sat_pkg::node_t clq_dout;
    logic           load_pend;
    sat_pkg::node_t load_node;
    logic [SLOT_W:0] fill_cnt;
    logic [SLOT_W-1:0] fill_idx;

    // broadcast path
    logic          out_pop;
    logic          out_empty;
    sat_pkg::lit_t out_dout;
    sat_pkg::lit_t cur_lit;
    logic          upd;

    // scan
    logic [SLOT_W-1:0] slot;
    logic              running;
    logic              done;
    logic              scan_en;
    logic              in_full;

    // clause store and per slot status
    sat_pkg::node_t       store [CLQ_DEPTH];
    logic [CLQ_DEPTH-1:0] occ;
    logic [CLQ_DEPTH-1:0] sat;
    logic [CLQ_DEPTH-1:0] emit;
    logic [NL-1:0]        fls [CLQ_DEPTH];

    // current slot evaluation
    sat_pkg::node_t cur_node;
    logic [1:0]     free_cnt;
    sat_pkg::lit_t  unit_lit;
    logic           cur_sat;
    logic           slot_live;
    logic           in_push;
    logic           conf_hit;

    // only nodes tagged for this engine
    assign clq_push = clause_push && (clause_node.eng == sat_pkg::ENG_W'(ENG_ID));
    assign clq_pop  = !clq_empty;
    assign fill_idx = fill_cnt[SLOT_W-1:0];

    lit_fifo #(.DEPTH(UCQ_DEPTH), .item_t(sat_pkg::node_t)) i_clq (
        .clk(clk), .rst_n(rst_n),
        .push(clq_push), .din(clause_node), .pop(clq_pop),
        .dout(clq_dout), .full(clause_full), .empty(clq_empty)
    );

    // broadcast literals from the arbiter
    lit_fifo #(.DEPTH(UCQ_DEPTH), .item_t(sat_pkg::lit_t)) i_ucq_out (
        .clk(clk), .rst_n(rst_n),
        .push(bcast_push), .din(bcast_lit), .pop(out_pop),
        .dout(out_dout), .full(ucq_out_full), .empty(out_empty)
    );

    // unit literals toward the arbiter
    lit_fifo #(.DEPTH(UCQ_DEPTH), .item_t(sat_pkg::lit_t)) i_ucq_in (
        .clk(clk), .rst_n(rst_n),
        .push(in_push), .din(unit_lit), .pop(ucq_in_pop),
        .dout(ucq_in_lit), .full(in_full), .empty(ucq_in_empty)
    );

    // scan stalls while the unit queue is full
    assign scan_en = !in_full;

    scan_counter #(.CLQ_DEPTH(CLQ_DEPTH)) i_scan (
        .clk(clk), .rst_n(rst_n),
        .start(upd), .enable(scan_en),
        .slot(slot), .running(running), .done(done)
    );

    // next literal may be taken on the last scan cycle
    assign out_pop = !out_empty && !upd && (!running || done);

    always_ff @(posedge clk) begin
        if (out_pop) begin
            cur_lit <= out_dout;
        end
        if (clq_pop) begin
            load_node <= clq_dout;
        end
        // overflow nodes are dropped
        if (load_pend && (fill_cnt < CLQ_DEPTH)) begin
            store[fill_idx] <= load_node;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            upd       <= 1'b0;
            load_pend <= 1'b0;
            fill_cnt  <= '0;
        end else begin
            upd       <= out_pop;
            load_pend <= clq_pop;
            if (load_pend && (fill_cnt < CLQ_DEPTH)) begin
                fill_cnt <= fill_cnt + 1'b1;
            end
        end
    end

    // count positions not yet false in the scanned slot
    assign cur_node = store[slot];

    always_comb begin
        free_cnt = '0;
        unit_lit = '0;
        cur_sat  = 1'b0;
        for (int p = 0; p < NL; p++) begin
            if (cur_node.mask[p] && !fls[slot][p]) begin
                free_cnt = free_cnt + 1'b1;
                unit_lit = cur_node.lits[p];
            end
            // slot holds the literal being scanned for
            if (cur_node.mask[p] && (cur_node.lits[p] == cur_lit)) begin
                cur_sat = 1'b1;
            end
        end
    end

    assign slot_live = running && scan_en && occ[slot] && !sat[slot] && !emit[slot];
    assign in_push   = slot_live && (free_cnt == 2'd1);
    assign conf_hit  = slot_live && (free_cnt == 2'd0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            occ      <= '0;
            sat      <= '0;
            emit     <= '0;
            conflict <= 1'b0;
            for (int s = 0; s < CLQ_DEPTH; s++) begin
                fls[s] <= '0;
            end
        end else begin
            // one cycle marks every slot against the new literal
            if (upd) begin
                for (int s = 0; s < CLQ_DEPTH; s++) begin
                    for (int p = 0; p < NL; p++) begin
                        if (occ[s] && store[s].mask[p] &&
                            (store[s].lits[p].var_idx == cur_lit.var_idx)) begin
                            if (store[s].lits[p].sign == cur_lit.sign) begin
                                sat[s] <= 1'b1;
                            end else begin
                                fls[s][p] <= 1'b1;
                            end
                        end
                    end
                end
            end
            if (in_push) begin
                emit[slot] <= 1'b1;
            end
            if (conf_hit) begin
                conflict <= 1'b1;
            end
            // fresh slot starts with clean status
            if (load_pend && (fill_cnt < CLQ_DEPTH)) begin
                occ[fill_idx]  <= 1'b1;
                sat[fill_idx]  <= 1'b0;
                emit[fill_idx] <= 1'b0;
                fls[fill_idx]  <= '0;
            end
        end
    end

    assign busy = !clq_empty || load_pend || !out_empty || upd || running || !ucq_in_empty;

    // a slot satisfied by the current literal never emits a unit
    a_unit_unsat: assert property (@(posedge clk) disable iff (!rst_n)
        in_push |-> !cur_sat);

endmodule

`default_nettype wire

/* hw/model_stack.sv */
`timescale 1ns/1ps
`default_nettype none

module model_stack (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [sat_pkg::VAR_W-1:0] lookup_var,
    input  logic                      commit_push,
    input  sat_pkg::lit_t             commit_lit,
    output logic                      assigned,
    output logic                      assigned_sign,
    output logic [sat_pkg::VAR_W:0]   depth
);

    localparam int NVAR = 1 << sat_pkg::VAR_W;

    // assignment table, one bit and a sign per variable
    logic [NVAR-1:0] asg;
    logic [NVAR-1:0] sgn;
    // committed literals in order
    sat_pkg::lit_t   stack [NVAR];

    always_ff @(posedge clk) begin
        if (commit_push) begin
            sgn[commit_lit.var_idx]           <= commit_lit.sign;
            stack[depth[sat_pkg::VAR_W-1:0]] <= commit_lit;
        end
        assigned_sign <= sgn[lookup_var];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            asg      <= '0;
            depth    <= '0;
            assigned <= 1'b0;
        end else begin
            if (commit_push) begin
                asg[commit_lit.var_idx] <= 1'b1;
                depth                   <= depth + 1'b1;
            end
            // lookup result one cycle later
            assigned <= asg[lookup_var];
        end
    end

    // arbiter check must filter repeats
    a_no_reassign: assert property (@(posedge clk) disable iff (!rst_n)
        commit_push |-> !asg[commit_lit.var_idx]);

endmodule

`default_nettype wire

/* hw/uc_arbiter_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module uc_arbiter_fsm #(
    parameter int NUM_ENGINE = 4
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            halt,
    input  sat_pkg::lit_t                   seed_lit,
    input  logic                            seed_valid,
    input  sat_pkg::lit_t [NUM_ENGINE-1:0] ucq_in_lit,
    input  logic [NUM_ENGINE-1:0]           ucq_in_empty,
    input  logic [NUM_ENGINE-1:0]           ucq_out_full,
    input  logic                            assigned,
    input  logic                            assigned_sign,
    output logic                            seed_ready,
    output logic [NUM_ENGINE-1:0]           ucq_in_pop,
    output logic [sat_pkg::VAR_W-1:0]       lookup_var,
    output sat_pkg::lit_t                   bcast_lit,
    output logic                            bcast_push,
    output sat_pkg::lit_t                   commit_lit,
    output logic                            commit_push,
    output logic                            conflict,
    output logic                            waiting
);

    typedef enum logic [3:0] {
        S_WAIT   = 4'b0001,
        S_PICK   = 4'b0010,
        S_CHECK  = 4'b0100,
        S_COMMIT = 4'b1000
    } state_t;

    state_t                    state;
    state_t                    state_nx;
    logic [sat_pkg::ENG_W-1:0] rr_ptr;
    logic [sat_pkg::ENG_W-1:0] eng_sel;
    logic                      eng_any;
    logic                      go;
    logic                      take;
    sat_pkg::lit_t             pick_lit;
    sat_pkg::lit_t             cur_lit;

    // halt freezes every transition and pulse
    assign go = !halt;

    // round robin, first non-empty queue at or after rr_ptr
    always_comb begin
        int idx;
        eng_any = 1'b0;
        eng_sel = rr_ptr;
        for (int k = NUM_ENGINE - 1; k >= 0; k--) begin
            idx = (int'(rr_ptr) + k) % NUM_ENGINE;
            if (!ucq_in_empty[idx]) begin
                eng_any = 1'b1;
                eng_sel = sat_pkg::ENG_W'(idx);
            end
        end
    end

    // seed wins over engine units
    assign pick_lit   = seed_valid ? seed_lit : ucq_in_lit[eng_sel];
    assign take       = (state == S_PICK) && go;
    assign seed_ready = take && seed_valid;

    always_comb begin
        for (int k = 0; k < NUM_ENGINE; k++) begin
            ucq_in_pop[k] = take && !seed_valid && eng_any && (int'(eng_sel) == k);
        end
    end

    // lookup issued in pick so the result lands in check
    assign lookup_var  = (state == S_PICK) ? pick_lit.var_idx : cur_lit.var_idx;
    // all engines take the literal together
    assign commit_push = (state == S_COMMIT) && go && !(|ucq_out_full);
    assign commit_lit  = cur_lit;
    assign bcast_push  = commit_push;
    assign bcast_lit   = cur_lit;
    assign waiting     = (state == S_WAIT);

    always_comb begin
        state_nx = state;
        case (state)
            S_WAIT: begin
                if (go && (seed_valid || eng_any)) begin
                    state_nx = S_PICK;
                end
            end
            S_PICK: begin
                if (go) begin
                    state_nx = (seed_valid || eng_any) ? S_CHECK : S_WAIT;
                end
            end
            S_CHECK: begin
                // assigned literals are dropped or flagged
                if (go) begin
                    state_nx = assigned ? S_WAIT : S_COMMIT;
                end
            end
            S_COMMIT: begin
                if (commit_push) begin
                    state_nx = S_WAIT;
                end
            end
            default: state_nx = S_WAIT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (take) begin
            cur_lit <= pick_lit;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= S_WAIT;
            rr_ptr   <= '0;
            conflict <= 1'b0;
        end else begin
            state <= state_nx;
            if (take && !seed_valid && eng_any) begin
                rr_ptr <= sat_pkg::ENG_W'((int'(eng_sel) + 1) % NUM_ENGINE);
            end
            // opposite sign already in the model
            if ((state == S_CHECK) && go && assigned && (assigned_sign != cur_lit.sign)) begin
                conflict <= 1'b1;
            end
        end
    end

    a_state_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot(state));

endmodule

`default_nettype wire

/* hw/sat_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sat_top #(
    parameter int NUM_ENGINE = 4,
    parameter int CLQ_DEPTH  = 8,
    parameter int UCQ_DEPTH  = 4
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           halt,
    input  sat_pkg::node_t clause_node,
    input  logic           clause_push,
    input  sat_pkg::lit_t  seed_lit,
    input  logic           seed_valid,
    output logic           clause_full,
    output logic           seed_ready,
    output sat_pkg::lit_t  assign_lit,
    output logic           assign_valid,
    output logic           conflict,
    output logic           idle
);

    // engine to arbiter
    sat_pkg::lit_t [NUM_ENGINE-1:0] ucq_in_lit;
    logic [NUM_ENGINE-1:0]          ucq_in_empty;
    logic [NUM_ENGINE-1:0]          ucq_in_pop;
    // arbiter to engines
    logic [NUM_ENGINE-1:0]          ucq_out_full;
    sat_pkg::lit_t                  bcast_lit;
    logic                           bcast_push;
    // per engine flags
    logic [NUM_ENGINE-1:0]          eng_clause_full;
    logic [NUM_ENGINE-1:0]          eng_conflict;
    logic [NUM_ENGINE-1:0]          eng_busy;
    // model stack
    logic [sat_pkg::VAR_W-1:0]      lookup_var;
    logic                           assigned;
    logic                           assigned_sign;
    sat_pkg::lit_t                  commit_lit;
    logic                           commit_push;
    logic                           arb_conflict;
    logic                           arb_waiting;

    assign clause_full  = |eng_clause_full;
    assign conflict     = arb_conflict | (|eng_conflict);
    assign idle         = arb_waiting && !seed_valid && !(|eng_busy);
    // every commit is reported outside
    assign assign_valid = commit_push;
    assign assign_lit   = commit_lit;

    for (genvar g = 0; g < NUM_ENGINE; g++) begin : g_eng
        bcp_engine #(
            .ENG_ID(g), .CLQ_DEPTH(CLQ_DEPTH), .UCQ_DEPTH(UCQ_DEPTH)
        ) i_eng (
            .clk(clk), .rst_n(rst_n),
            .clause_node(clause_node), .clause_push(clause_push),
            .bcast_lit(bcast_lit), .bcast_push(bcast_push),
            .ucq_in_pop(ucq_in_pop[g]),
            .clause_full(eng_clause_full[g]), .ucq_out_full(ucq_out_full[g]),
            .ucq_in_lit(ucq_in_lit[g]), .ucq_in_empty(ucq_in_empty[g]),
            .conflict(eng_conflict[g]), .busy(eng_busy[g])
        );
    end

    uc_arbiter_fsm #(.NUM_ENGINE(NUM_ENGINE)) i_arb (
        .clk(clk), .rst_n(rst_n), .halt(halt),
        .seed_lit(seed_lit), .seed_valid(seed_valid),
        .ucq_in_lit(ucq_in_lit), .ucq_in_empty(ucq_in_empty),
        .ucq_out_full(ucq_out_full),
        .assigned(assigned), .assigned_sign(assigned_sign),
        .seed_ready(seed_ready), .ucq_in_pop(ucq_in_pop),
        .lookup_var(lookup_var),
        .bcast_lit(bcast_lit), .bcast_push(bcast_push),
        .commit_lit(commit_lit), .commit_push(commit_push),
        .conflict(arb_conflict), .waiting(arb_waiting)
    );

    // depth left for hierarchical inspection
    model_stack i_mstack (
        .clk(clk), .rst_n(rst_n),
        .lookup_var(lookup_var),
        .commit_push(commit_push), .commit_lit(commit_lit),
        .assigned(assigned), .assigned_sign(assigned_sign),
        .depth()
    );

endmodule

`default_nettype wire

/* bench/tb_sat_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sat_top;

    localparam int NUM_ENGINE  = 4;
    localparam int NVAR        = 1 << sat_pkg::VAR_W;
    localparam int IDLE_LIMIT  = 3000;
    localparam int READY_LIMIT = 300;

    logic           clk;
    logic           rst_n;
    logic           halt;
    sat_pkg::node_t clause_node;
    logic           clause_push;
    sat_pkg::lit_t  seed_lit;
    logic           seed_valid;
    logic           clause_full;
    logic           seed_ready;
    sat_pkg::lit_t  assign_lit;
    logic           assign_valid;
    logic           conflict;
    logic           idle;

    // clause set of the current test
    sat_pkg::node_t  clauses [$];
    // reference model result
    bit [NVAR-1:0]   exp_asg;
    bit [NVAR-1:0]   exp_sgn;
    bit              exp_conf;
    sat_pkg::lit_t   exp_order [$];
    // commits seen on the DUT outputs
    int              seen_cnt [NVAR];
    sat_pkg::lit_t   got_order [$];
    string           test_name;
    bit              order_check;
    int              rand_seed = 32'h2d166a01;

    sat_top #(.NUM_ENGINE(NUM_ENGINE), .CLQ_DEPTH(8), .UCQ_DEPTH(4)) i_dut (
        .clk(clk), .rst_n(rst_n), .halt(halt),
        .clause_node(clause_node), .clause_push(clause_push),
        .seed_lit(seed_lit), .seed_valid(seed_valid),
        .clause_full(clause_full), .seed_ready(seed_ready),
        .assign_lit(assign_lit), .assign_valid(assign_valid),
        .conflict(conflict), .idle(idle)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic report_mismatch(input string what, input string exp_s, input string act_s);
        stop_on_error($sformatf("Mismatch %s %s expected %s actual %s",
            test_name, what, exp_s, act_s));
    endtask

    function automatic string lit_str(input sat_pkg::lit_t l);
        return $sformatf("%s%0d", l.sign ? "-" : "+", l.var_idx);
    endfunction

    function automatic sat_pkg::lit_t mk_lit(input int v, input bit neg);
        sat_pkg::lit_t l;
        l.sign    = neg;
        l.var_idx = sat_pkg::VAR_W'(v);
        return l;
    endfunction

    // commit log, sampled mid cycle where outputs are settled
    always @(negedge clk) begin
        if (!rst_n) begin
            foreach (seen_cnt[i]) begin
                seen_cnt[i] = 0;
            end
            got_order.delete();
        end else if (assign_valid) begin
            seen_cnt[assign_lit.var_idx] = seen_cnt[assign_lit.var_idx] + 1;
            got_order.push_back(assign_lit);
        end
    end

    // arbiter frozen means no commit
    halt_blocks_commit: assert property (@(posedge clk) disable iff (!rst_n)
        halt |-> !assign_valid)
        else stop_on_error($sformatf("commit while halt was high in %s", test_name));

    // var 0 never names a real literal
    commit_var_legal: assert property (@(posedge clk) disable iff (!rst_n)
        assign_valid |-> (assign_lit.var_idx != '0))
        else stop_on_error($sformatf("commit of reserved variable 0 in %s", test_name));

    // each variable committed once at most
    commit_once: assert property (@(posedge clk) disable iff (!rst_n)
        assign_valid |-> (seen_cnt[assign_lit.var_idx] == 1))
        else stop_on_error($sformatf("variable committed twice in %s", test_name));

    // commit must lie inside the predicted closure unless a conflict is due
    commit_in_model: assert property (@(posedge clk) disable iff (!rst_n)
        assign_valid |-> (exp_conf || (exp_asg[assign_lit.var_idx] &&
            (exp_sgn[assign_lit.var_idx] == assign_lit.sign))))
        else stop_on_error($sformatf("commit outside predicted assignment in %s", test_name));

    conflict_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        conflict |=> conflict)
        else stop_on_error($sformatf("conflict dropped before reset in %s", test_name));

    task automatic apply_reset();
        @(posedge clk);
        #1;
        rst_n       = 1'b0;
        halt        = 1'b0;
        clause_push = 1'b0;
        clause_node = '0;
        seed_valid  = 1'b0;
        seed_lit    = '0;
        clauses.delete();
        exp_order.delete();
        exp_asg     = '0;
        exp_sgn     = '0;
        exp_conf    = 1'b0;
        order_check = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
    endtask

    // returns on a falling edge with idle high
    task automatic wait_idle();
        int cnt;
        cnt = 0;
        @(negedge clk);
        while (!idle) begin
            if (cnt == IDLE_LIMIT) begin
                stop_on_error($sformatf("timeout waiting for idle in %s", test_name));
            end
            cnt++;
            @(negedge clk);
        end
    endtask

    task automatic add_clause(input int eng, input sat_pkg::lit_t a, input sat_pkg::lit_t b,
                              input sat_pkg::lit_t c, input logic [2:0] mask);
        sat_pkg::node_t n;
        n.eng     = sat_pkg::ENG_W'(eng);
        n.lits[0] = a;
        n.lits[1] = b;
        n.lits[2] = c;
        n.mask    = mask;
        clauses.push_back(n);
    endtask

    // one node per idle window
    task automatic load_clauses();
        foreach (clauses[i]) begin
            wait_idle();
            assert (!clause_full) else stop_on_error("clause queue full while idle");
            @(posedge clk);
            #1;
            clause_node = clauses[i];
            clause_push = 1'b1;
            @(posedge clk);
            #1;
            clause_push = 1'b0;
        end
        wait_idle();
    endtask

    task automatic offer_seed(input sat_pkg::lit_t l);
        @(posedge clk);
        #1;
        seed_lit   = l;
        seed_valid = 1'b1;
    endtask

    // transfer happens on the edge after ready is seen
    task automatic await_seed();
        int cnt;
        cnt = 0;
        @(negedge clk);
        while (!seed_ready) begin
            if (cnt == READY_LIMIT) begin
                stop_on_error($sformatf("timeout waiting for seed_ready in %s", test_name));
            end
            cnt++;
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        seed_valid = 1'b0;
    endtask

    // plain unit propagation to a fixed point
    task automatic run_reference(input sat_pkg::lit_t seed);
        sat_pkg::lit_t work [$];
        sat_pkg::lit_t l;
        sat_pkg::lit_t last_free;
        sat_pkg::lit_t q;
        int            n_free;
        bit            is_sat;
        work.push_back(seed);
        while (work.size() > 0) begin
            l = work.pop_front();
            if (exp_asg[l.var_idx]) begin
                if (exp_sgn[l.var_idx] != l.sign) begin
                    exp_conf = 1'b1;
                end
            end else begin
                exp_asg[l.var_idx] = 1'b1;
                exp_sgn[l.var_idx] = l.sign;
                exp_order.push_back(l);
                foreach (clauses[c]) begin
                    is_sat    = 1'b0;
                    n_free    = 0;
                    last_free = '0;
                    for (int p = 0; p < sat_pkg::CLA_LITS; p++) begin
                        q = clauses[c].lits[p];
                        if (clauses[c].mask[p]) begin
                            if (!exp_asg[q.var_idx]) begin
                                n_free++;
                                last_free = q;
                            end else if (exp_sgn[q.var_idx] == q.sign) begin
                                is_sat = 1'b1;
                            end
                        end
                    end
                    if (!is_sat && (n_free == 0)) begin
                        exp_conf = 1'b1;
                    end else if (!is_sat && (n_free == 1)) begin
                        work.push_back(last_free);
                    end
                end
            end
        end
    endtask

    task automatic check_result();
        assert (conflict == exp_conf)
            else report_mismatch("conflict", $sformatf("%0b", exp_conf),
                $sformatf("%0b", conflict));
        // after a conflict the commit set depends on order
        if (!exp_conf) begin
            assert (got_order.size() == exp_order.size())
                else report_mismatch("commit count", $sformatf("%0d", exp_order.size()),
                    $sformatf("%0d", got_order.size()));
            assert (i_dut.i_mstack.depth == exp_order.size())
                else report_mismatch("model depth", $sformatf("%0d", exp_order.size()),
                    $sformatf("%0d", i_dut.i_mstack.depth));
            foreach (exp_order[i]) begin
                assert (seen_cnt[exp_order[i].var_idx] == 1)
                    else report_mismatch("commits of var", $sformatf("%0d", 1),
                        $sformatf("%0d", seen_cnt[exp_order[i].var_idx]));
                if (order_check) begin
                    assert (got_order[i] == exp_order[i])
                        else report_mismatch($sformatf("commit %0d", i),
                            lit_str(exp_order[i]), lit_str(got_order[i]));
                end
            end
        end
    endtask

    task automatic run_case(input sat_pkg::lit_t s);
        run_reference(s);
        load_clauses();
        offer_seed(s);
        await_seed();
        wait_idle();
        check_result();
    endtask

    // three distinct vars out of 1..8, engine tag spread evenly
    task automatic build_random_set(input int ncl);
        int v0;
        int v1;
        int v2;
        bit s0;
        bit s1;
        bit s2;
        for (int c = 0; c < ncl; c++) begin
            v0 = ($random(rand_seed) & 7) + 1;
            v1 = (v0 + (($random(rand_seed) & 32'h7fffffff) % 7)) % 8 + 1;
            do begin
                v2 = ($random(rand_seed) & 7) + 1;
            end while ((v2 == v0) || (v2 == v1));
            s0 = 1'($random(rand_seed));
            s1 = 1'($random(rand_seed));
            s2 = 1'($random(rand_seed));
            add_clause(c % NUM_ENGINE, mk_lit(v0, s0), mk_lit(v1, s1), mk_lit(v2, s2), 3'b111);
        end
    endtask

    initial begin
        int  rv;
        bit  rs;
        rst_n       = 1'b0;
        halt        = 1'b0;
        clause_push = 1'b0;
        clause_node = '0;
        seed_valid  = 1'b0;
        seed_lit    = '0;

        test_name = "reset";
        apply_reset();
        @(negedge clk);
        assert (!conflict) else report_mismatch("conflict", "0", $sformatf("%0b", conflict));
        assert (!assign_valid)
            else report_mismatch("assign_valid", "0", $sformatf("%0b", assign_valid));
        assert (!seed_ready) else report_mismatch("seed_ready", "0", $sformatf("%0b", seed_ready));
        wait_idle();

        // no clauses, the seed alone commits
        test_name = "single_seed";
        apply_reset();
        order_check = 1'b1;
        run_case(mk_lit(3, 1'b0));

        // x1 -> x2 -> ... -> x6, links on rotating engines
        test_name = "chain";
        apply_reset();
        order_check = 1'b1;
        for (int k = 1; k <= 5; k++) begin
            add_clause(k % NUM_ENGINE, mk_lit(k, 1'b1), mk_lit(k + 1, 1'b0), '0, 3'b011);
        end
        run_case(mk_lit(1, 1'b0));

        // engines 0 and 2 both imply x7
        test_name = "shared_unit";
        apply_reset();
        add_clause(0, mk_lit(2, 1'b1), mk_lit(7, 1'b0), '0, 3'b011);
        add_clause(2, mk_lit(2, 1'b1), mk_lit(7, 1'b0), '0, 3'b011);
        add_clause(1, mk_lit(7, 1'b1), mk_lit(9, 1'b0), '0, 3'b011);
        run_case(mk_lit(2, 1'b0));

        // x4 implies both x5 and -x5
        test_name = "conflict";
        apply_reset();
        add_clause(1, mk_lit(4, 1'b1), mk_lit(5, 1'b0), '0, 3'b011);
        add_clause(3, mk_lit(4, 1'b1), mk_lit(5, 1'b1), '0, 3'b011);
        run_case(mk_lit(4, 1'b0));
        repeat (16) begin
            @(negedge clk);
            assert (conflict) else report_mismatch("held conflict", "1", "0");
        end
        apply_reset();
        @(negedge clk);
        assert (!conflict) else report_mismatch("conflict after reset", "0", "1");

        test_name = "halt";
        apply_reset();
        for (int k = 0; k < 3; k++) begin
            add_clause(k + 1, mk_lit(20 + k, 1'b1), mk_lit(21 + k, 1'b0), '0, 3'b011);
        end
        run_reference(mk_lit(20, 1'b0));
        load_clauses();
        @(posedge clk);
        #1;
        halt = 1'b1;
        offer_seed(mk_lit(20, 1'b0));
        // frozen arbiter leaves the seed waiting
        repeat (24) begin
            @(negedge clk);
            assert (!seed_ready) else stop_on_error("seed accepted while halt was high");
        end
        @(posedge clk);
        #1;
        halt = 1'b0;
        await_seed();
        // freeze again before the seed commits
        halt = 1'b1;
        repeat (20) @(posedge clk);
        #1;
        halt = 1'b0;
        wait_idle();
        check_result();

        for (int it = 0; it < 20; it++) begin
            test_name = $sformatf("random_%0d", it);
            apply_reset();
            build_random_set(14);
            rv = ($random(rand_seed) & 7) + 1;
            rs = 1'($random(rand_seed));
            run_case(mk_lit(rv, rs));
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
hw/sat_pkg.sv
hw/lit_fifo.sv
hw/scan_counter.sv
hw/bcp_engine.sv
hw/model_stack.sv
hw/uc_arbiter_fsm.sv
hw/sat_top.sv
bench/tb_sat_top.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module tb_sat_top -f tb.f -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -qx 'STATUS: PASS' \
    && echo "run_sim: simulation passed" \
    || { echo "run_sim: simulation failed"; exit 1; }
